//--- Bender.yml
package:
  name: adxl355_frontend

sources:
  - logic/adxl355_pkg.sv
  - logic/adxl355_clk.sv
  - logic/adxl355_spi_reader.sv
  - logic/adxl355_wb_regs.sv
  - logic/adxl355_top.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/adxl355_sensor_model.sv
      - verification/tb_adxl355_top.sv

//--- flist.f
logic/adxl355_pkg.sv
logic/adxl355_clk.sv
logic/adxl355_spi_reader.sv
logic/adxl355_wb_regs.sv
logic/adxl355_top.sv
verification/tb_clk_gen.sv
verification/adxl355_sensor_model.sv
verification/tb_adxl355_top.sv

//--- logic/adxl355_clk.sv
// sync phase accumulator with programmable increment and pps interval tolerance checker
`timescale 1ns/1ps
`default_nettype none

module adxl355_clk
  import adxl355_pkg::*;
#(
  parameter int unsigned clk_out0_hz = 40_000_000, // Hz, system clock
  parameter int unsigned pps_hz      = 1,          // Hz, pps rate
  parameter int unsigned pps_s       = 1,          // s, pps period multiplier
  parameter int unsigned pps_tol_us  = 500         // us, +- pps tolerance
)
(
  input  wire  i_clk,
  input  wire  i_rst_n,
  input  pa_t  i_pa_inc,    // accumulator step, from register block
  input  wire  i_pps,       // gps pulse per second, asynchronous
  output logic o_clk_sync,  // sensor sync clock
  output logic o_pps_valid  // 1 when last pps interval was inside the window
);

  // window bounds in clock cycles, worked out at elaboration
  localparam real pps_period_cyc = 1.0 * clk_out0_hz * pps_s / pps_hz;
  localparam real pps_tol_cyc    = 1.0 * pps_tol_us * clk_out0_hz / 1.0e6;
  localparam logic [31:0] pps_min_cnt = 32'($rtoi(pps_period_cyc - pps_tol_cyc));
  localparam logic [31:0] pps_max_cnt = 32'($rtoi(pps_period_cyc + pps_tol_cyc));
  // counter holds interval-1 at an edge, pending flag is set one cycle late
  localparam logic [31:0] pps_pend_cnt = pps_min_cnt - 32'd2;

  pa_t         pa_sync;     // phase accumulator
  logic [1:0]  pps_shift;   // [1] newest, [0] older sample of i_pps
  logic [31:0] cnt_pps;     // cycles since last pps edge
  logic        pps_pend;    // interval has passed the lower bound
  logic        pps_edge;
  logic        pps_timeout;

  // accumulator wraps freely, msb is a square wave at f = inc/2^32 * f_clk
  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      pa_sync <= '0;
    else
      pa_sync <= pa_sync + i_pa_inc; // new increment used the cycle after a write
  end

  assign o_clk_sync = pa_sync[31];

  assign pps_edge    = (pps_shift == 2'b10);     // low then high
  assign pps_timeout = (cnt_pps == pps_max_cnt); // no pulse within upper bound

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      pps_shift   <= 2'b00;
      cnt_pps     <= '0;
      pps_pend    <= 1'b0;
      o_pps_valid <= 1'b0;
    end
    else
    begin
      pps_shift <= {i_pps, pps_shift[1]}; // two stage sampler doubles as edge detector
      if (pps_edge || pps_timeout)
      begin
        o_pps_valid <= pps_pend && !pps_timeout; // judged only here
        cnt_pps     <= '0;                       // restart interval
      end
      else
        cnt_pps <= cnt_pps + 32'd1;

      if (pps_edge || pps_timeout)
        pps_pend <= 1'b0;                        // new interval starts unqualified
      else if (cnt_pps == pps_pend_cnt)
        pps_pend <= 1'b1;                        // early limit passed
    end
  end

endmodule

`default_nettype wire

//--- logic/adxl355_pkg.sv
// shared vector types, register map indices and spi command constants for the adxl355 front end
`default_nettype none

package adxl355_pkg;

  typedef logic [31:0]        pa_t;      // sync phase accumulator word and increment
  typedef logic signed [19:0] axis_t;    // one acceleration sample, two's complement
  typedef logic [2:0]         wb_addr_t; // wishbone word address
  typedef logic [31:0]        wb_data_t; // wishbone data word

  // register map, word addresses
  localparam wb_addr_t reg_ctrl   = 3'd0; // bit0 enable rw, bit1 pps_valid ro
  localparam wb_addr_t reg_pa_inc = 3'd1; // sync accumulator increment rw
  localparam wb_addr_t reg_x      = 3'd2; // latest x sample, sign-extended ro
  localparam wb_addr_t reg_y      = 3'd3; // latest y sample, sign-extended ro
  localparam wb_addr_t reg_z      = 3'd4; // latest z sample, sign-extended ro
  localparam wb_addr_t reg_count  = 3'd5; // completed sample counter ro

  // sensor spi protocol
  localparam logic [7:0] spi_rd_xdata = 8'h11; // (0x08 << 1) | read bit
  localparam int         spi_rd_bytes = 9;     // xdata3..zdata1

endpackage

`default_nettype wire

//--- logic/adxl355_spi_reader.sv
// spi mode 0 master that reads the nine xyz data bytes after each sync rising edge
`timescale 1ns/1ps
`default_nettype none

module adxl355_spi_reader
  import adxl355_pkg::*;
#(
  parameter int unsigned spi_div = 2 // clock cycles per sclk half period
)
(
  input  wire   i_clk,
  input  wire   i_rst_n,
  input  wire   i_clk_sync,     // sync clock from accumulator, same domain
  input  wire   i_enable,       // reading enabled by host
  input  wire   i_spi_miso,
  output logic  o_spi_sclk,
  output logic  o_spi_cs_n,
  output logic  o_spi_mosi,
  output axis_t o_sample_x,
  output axis_t o_sample_y,
  output axis_t o_sample_z,
  output logic  o_sample_valid  // one cycle, with cs rise
);

  localparam int n_data_bits = 8 * spi_rd_bytes;                // 72 bits after command
  localparam int div_w       = (spi_div > 1) ? $clog2(spi_div) : 1;

  typedef enum logic [1:0] {
    st_idle,
    st_command,
    st_data,
    st_finish
  } state_t;

  state_t                 state;
  logic                   sync_q;    // previous sync level
  logic                   sync_rise;
  logic [div_w-1:0]       div_cnt;   // half period divider
  logic                   tick;      // end of half period
  logic [6:0]             bit_cnt;   // bit index inside current phase
  logic [7:0]             tx_sr;     // command shift register
  logic [n_data_bits-1:0] rx_sr;     // received data, msb first

  assign sync_rise  = i_clk_sync && !sync_q;
  assign tick       = (div_cnt == div_w'(spi_div - 1));
  assign o_spi_mosi = tx_sr[7];      // zeros follow the command

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      state          <= st_idle;
      sync_q         <= 1'b0;
      div_cnt        <= '0;
      bit_cnt        <= '0;
      tx_sr          <= '0;
      o_spi_sclk     <= 1'b0;
      o_spi_cs_n     <= 1'b1;
      o_sample_valid <= 1'b0;
    end
    else
    begin
      sync_q         <= i_clk_sync;
      o_sample_valid <= 1'b0;
      if (state != st_idle)
        div_cnt <= tick ? '0 : div_cnt + 1'b1;

      case (state)
        st_idle:
          if (sync_rise && i_enable) // edges during a transfer never reach here
          begin
            state      <= st_command;
            o_spi_cs_n <= 1'b0;
            div_cnt    <= '0;
            bit_cnt    <= '0;
            tx_sr      <= spi_rd_xdata; // first bit set up before first rise
          end
        st_command:
          if (tick)
          begin
            if (!o_spi_sclk)
              o_spi_sclk <= 1'b1;
            else
            begin
              o_spi_sclk <= 1'b0;
              tx_sr      <= {tx_sr[6:0], 1'b0}; // mosi moves on falling edge
              if (bit_cnt == 7'd7)
              begin
                bit_cnt <= '0;
                state   <= st_data;
              end
              else
                bit_cnt <= bit_cnt + 7'd1;
            end
          end
        st_data:
          if (tick)
          begin
            if (!o_spi_sclk)
            begin
              o_spi_sclk <= 1'b1; // miso sampled in the rx block below
              if (bit_cnt == 7'(n_data_bits - 1))
                state <= st_finish;
            end
            else
            begin
              o_spi_sclk <= 1'b0;
              bit_cnt    <= bit_cnt + 7'd1;
            end
          end
        st_finish:
          if (tick) // half period after last rising edge
          begin
            o_spi_sclk     <= 1'b0;
            o_spi_cs_n     <= 1'b1;
            o_sample_valid <= 1'b1;
            state          <= st_idle;
          end
        default:
          state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (state == st_data && tick && !o_spi_sclk)
      rx_sr <= {rx_sr[n_data_bits-2:0], i_spi_miso}; // sample on rising sclk
  end

  // data regs are left-justified, upper 20 of each 24-bit triple
  assign o_sample_x = axis_t'(rx_sr[n_data_bits-1  -: 20]);
  assign o_sample_y = axis_t'(rx_sr[n_data_bits-25 -: 20]);
  assign o_sample_z = axis_t'(rx_sr[n_data_bits-49 -: 20]);

endmodule

`default_nettype wire

//--- logic/adxl355_top.sv
// adxl355 front end top level with reset increment calculation and block wiring
`timescale 1ns/1ps
`default_nettype none

module adxl355_top
  import adxl355_pkg::*;
#(
  parameter int unsigned clk_out0_hz = 40_000_000, // Hz, system clock
  parameter int unsigned clk_sync_hz = 1000,       // Hz, sensor sample rate
  parameter int unsigned pps_hz      = 1,          // Hz
  parameter int unsigned pps_s       = 1,          // s
  parameter int unsigned pps_tol_us  = 500,        // us, +- pps tolerance
  parameter int unsigned spi_div     = 2           // cycles per sclk half period
)
(
  input  wire      i_clk,
  input  wire      i_rst_n,
  input  wire      i_wb_cyc,
  input  wire      i_wb_stb,
  input  wire      i_wb_we,
  input  wb_addr_t i_wb_adr,
  input  wb_data_t i_wb_dat,
  output wb_data_t o_wb_dat,
  output logic     o_wb_ack,
  input  wire      i_pps,      // from gps
  output logic     o_clk_sync, // to sensor sync pin
  output logic     o_spi_sclk,
  output logic     o_spi_cs_n,
  output logic     o_spi_mosi,
  input  wire      i_spi_miso
);

  // 2^32 * f_sync / f_clk, truncated, 64-bit to avoid overflow
  localparam longint unsigned pa_inc_full = (64'd1 << 32) * clk_sync_hz / clk_out0_hz;
  localparam pa_t             pa_inc_rst  = pa_t'(pa_inc_full);

  pa_t   pa_inc;
  logic  pps_valid;
  logic  enable;
  axis_t sample_x;
  axis_t sample_y;
  axis_t sample_z;
  logic  sample_valid;

  adxl355_clk #(
    .clk_out0_hz (clk_out0_hz),
    .pps_hz      (pps_hz),
    .pps_s       (pps_s),
    .pps_tol_us  (pps_tol_us)
  ) i_clk_gen (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_pa_inc    (pa_inc),
    .i_pps       (i_pps),
    .o_clk_sync  (o_clk_sync),
    .o_pps_valid (pps_valid)
  );

  adxl355_spi_reader #(
    .spi_div (spi_div)
  ) i_spi_reader (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_clk_sync     (o_clk_sync),
    .i_enable       (enable),
    .i_spi_miso     (i_spi_miso),
    .o_spi_sclk     (o_spi_sclk),
    .o_spi_cs_n     (o_spi_cs_n),
    .o_spi_mosi     (o_spi_mosi),
    .o_sample_x     (sample_x),
    .o_sample_y     (sample_y),
    .o_sample_z     (sample_z),
    .o_sample_valid (sample_valid)
  );

  adxl355_wb_regs #(
    .pa_inc_rst (pa_inc_rst)
  ) i_wb_regs (
    .i_clk          (i_clk),
    .i_rst_n        (i_rst_n),
    .i_wb_cyc       (i_wb_cyc),
    .i_wb_stb       (i_wb_stb),
    .i_wb_we        (i_wb_we),
    .i_wb_adr       (i_wb_adr),
    .i_wb_dat       (i_wb_dat),
    .o_wb_dat       (o_wb_dat),
    .o_wb_ack       (o_wb_ack),
    .i_pps_valid    (pps_valid),
    .i_sample_x     (sample_x),
    .i_sample_y     (sample_y),
    .i_sample_z     (sample_z),
    .i_sample_valid (sample_valid),
    .o_enable       (enable),
    .o_pa_inc       (pa_inc)
  );

endmodule

`default_nettype wire

//--- logic/adxl355_wb_regs.sv
// wishbone classic slave with control, increment, status, sample snapshot and sample counter
`timescale 1ns/1ps
`default_nettype none

module adxl355_wb_regs
  import adxl355_pkg::*;
#(
  parameter pa_t pa_inc_rst = 32'd107374 // increment after reset
)
(
  input  wire      i_clk,
  input  wire      i_rst_n,
  input  wire      i_wb_cyc,
  input  wire      i_wb_stb,
  input  wire      i_wb_we,
  input  wb_addr_t i_wb_adr,
  input  wb_data_t i_wb_dat,
  output wb_data_t o_wb_dat,
  output logic     o_wb_ack,
  input  wire      i_pps_valid,
  input  axis_t    i_sample_x,
  input  axis_t    i_sample_y,
  input  axis_t    i_sample_z,
  input  wire      i_sample_valid,
  output logic     o_enable,
  output pa_t      o_pa_inc
);

  logic        access;  // new request this cycle
  logic        wr_en;
  axis_t       snap_x;  // sample snapshot
  axis_t       snap_y;
  axis_t       snap_z;
  logic [31:0] count;   // completed samples, wraps
  wb_data_t    rd_data;

  assign access = i_wb_cyc && i_wb_stb && !o_wb_ack; // held stb gets every other cycle
  assign wr_en  = access && i_wb_we;

  // read mux, unmapped words read zero
  always_comb
  begin
    case (i_wb_adr)
      reg_ctrl:   rd_data = {30'd0, i_pps_valid, o_enable};
      reg_pa_inc: rd_data = o_pa_inc;
      reg_x:      rd_data = {{12{snap_x[19]}}, snap_x};
      reg_y:      rd_data = {{12{snap_y[19]}}, snap_y};
      reg_z:      rd_data = {{12{snap_z[19]}}, snap_z};
      reg_count:  rd_data = count;
      default:    rd_data = '0;
    endcase
  end

  always_ff @(posedge i_clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
    begin
      o_wb_ack <= 1'b0;
      o_enable <= 1'b0;
      o_pa_inc <= pa_inc_rst;
      count    <= '0;
    end
    else
    begin
      o_wb_ack <= access; // single registered ack, no wait states
      if (wr_en && i_wb_adr == reg_ctrl)
        o_enable <= i_wb_dat[0]; // pps_valid bit is read only
      if (wr_en && i_wb_adr == reg_pa_inc)
        o_pa_inc <= i_wb_dat;
      if (i_sample_valid)
        count <= count + 32'd1;
    end
  end

  always_ff @(posedge i_clk)
  begin
    if (access)
      o_wb_dat <= rd_data; // valid in the ack cycle
    if (i_sample_valid)
    begin
      snap_x <= i_sample_x; // all three axes from one transfer
      snap_y <= i_sample_y;
      snap_z <= i_sample_z;
    end
  end

endmodule

`default_nettype wire

//--- verification/adxl355_sensor_model.sv
// behavioral adxl355 spi slave serving lfsr data bytes and recording the command byte
`timescale 1ns/1ps
`default_nettype none

module adxl355_sensor_model #(
  parameter logic [31:0] seed = 32'h52e3cbd3 // lfsr start value
)
(
  input  wire         i_sclk,
  input  wire         i_cs_n,
  input  wire         i_mosi,
  output logic        o_miso,
  output logic [7:0]  o_cmd,    // first byte of the latest transfer
  output logic [71:0] o_served  // data bytes of the latest transfer, msb first
);

  logic [31:0] lfsr;
  int          bit_idx;         // sclk rising edges since cs fell

  // fibonacci lfsr, taps 32 22 2 1, new bit enters at the bottom
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  initial
  begin
    lfsr     = seed;
    bit_idx  = 0;
    o_miso   = 1'b0;
    o_cmd    = '0;
    o_served = '0;
  end

  always @(negedge i_cs_n)
    bit_idx = 0;                // new transfer

  always @(posedge i_sclk)
  begin
    if (!i_cs_n)
    begin
      if (bit_idx < 8)
        o_cmd = {o_cmd[6:0], i_mosi}; // mode 0, mosi valid on rise
      bit_idx++;
    end
  end

  // next data bit goes out on the falling edge, ready for the next rise
  always @(negedge i_sclk)
  begin
    if (!i_cs_n && bit_idx >= 8 && bit_idx < 80)
    begin
      lfsr                   = lfsr_step(lfsr); // one step per served bit
      o_miso                 = lfsr[0];
      o_served[79 - bit_idx] = lfsr[0];
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_adxl355_top.sv
// testbench top for the adxl355 front end with wishbone tasks, pps stimulus and checks
`timescale 1ns/1ps
`default_nettype none

module tb_adxl355_top
  import adxl355_pkg::*;
();

  localparam int unsigned clk_hz  = 100000;
  localparam int unsigned sync_hz = 500;
  localparam pa_t exp_inc = 32'd21474836;                 // 2^32 / 200 = 21474836.48, truncated
  localparam logic [7:0] exp_cmd = (8'h08 << 1) | 8'h01; // xdata3, read

  logic       clk;
  logic       rst_n;
  logic       wb_cyc;
  logic       wb_stb;
  logic       wb_we;
  wb_addr_t   wb_adr;
  wb_data_t   wb_dat_w;
  wb_data_t   wb_dat_r;
  logic       wb_ack;
  logic       pps;
  logic       clk_sync;
  logic       sclk;
  logic       cs_n;
  logic       mosi;
  logic       miso;
  logic [7:0] seen_cmd;
  logic [71:0] served;
  logic       expect_idle;    // cs must stay high while set
  int         cyc_cnt = 0;    // free running cycle count
  int         cs_rise_cnt = 0;
  int         last_pps_cyc;
  int         err_cnt = 0;
  int         test_cnt = 0;
  int         fail_cnt = 0;
  int         test_err0;      // errors at test start

  tb_clk_gen #(.period_ns(40.0), .rst_cycles(4)) i_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

  adxl355_top #(
    .clk_out0_hz (clk_hz),
    .clk_sync_hz (sync_hz),
    .pps_hz      (1),
    .pps_s       (1),
    .pps_tol_us  (500),
    .spi_div     (2)
  ) i_dut (
    .i_clk      (clk),
    .i_rst_n    (rst_n),
    .i_wb_cyc   (wb_cyc),
    .i_wb_stb   (wb_stb),
    .i_wb_we    (wb_we),
    .i_wb_adr   (wb_adr),
    .i_wb_dat   (wb_dat_w),
    .o_wb_dat   (wb_dat_r),
    .o_wb_ack   (wb_ack),
    .i_pps      (pps),
    .o_clk_sync (clk_sync),
    .o_spi_sclk (sclk),
    .o_spi_cs_n (cs_n),
    .o_spi_mosi (mosi),
    .i_spi_miso (miso)
  );

  adxl355_sensor_model #(.seed(32'h52e3cbd3)) i_sensor (
    .i_sclk   (sclk),
    .i_cs_n   (cs_n),
    .i_mosi   (mosi),
    .o_miso   (miso),
    .o_cmd    (seen_cmd),
    .o_served (served)
  );

  always @(posedge clk)
    cyc_cnt <= cyc_cnt + 1;

  always @(posedge cs_n)
    if (rst_n)
      cs_rise_cnt++;          // one per completed transfer

  // ack is a one cycle pulse even with stb held
  ack_single: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |=> !wb_ack)
    else report_mismatch("o_wb_ack", 32'd1, 32'd0);
  // no transfer while reading is off
  cs_idle: assert property (@(posedge clk) disable iff (!rst_n) expect_idle |-> cs_n)
    else report_mismatch("o_spi_cs_n", 32'd0, 32'd1);

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp);
    err_cnt++;
  endtask

  task automatic abort_run(input string why);
    $display("ERROR: %s at %0t ns", why, $time);
    $display("Testbench failed");
    $finish;
  endtask

  task automatic begin_test();
    test_err0 = err_cnt;
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt != test_err0)
    begin
      fail_cnt++;
      $display("test %0d %s: FAILED with %0d errors", test_cnt, name, err_cnt - test_err0);
    end
    else
      $display("test %0d %s: ok", test_cnt, name);
  endtask

  // single classic cycle, inputs change 5 ns after the edge
  task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t wdat,
                           output wb_data_t rdat);
    int waited;
    @(posedge clk);
    #5;
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = wdat;
    waited   = 0;
    while (!wb_ack)
    begin
      if (waited == 16)
        abort_run("no wishbone ack within 16 cycles");
      @(posedge clk);
      #5;
      waited++;
    end
    rdat   = wb_dat_r;        // valid in the ack cycle
    @(posedge clk);           // stb still high here, slave must not ack again
    #5;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic wb_write(input wb_addr_t adr, input wb_data_t wdat);
    wb_data_t unused;
    wb_access(1'b1, adr, wdat, unused);
  endtask

  task automatic wb_read(input wb_addr_t adr, output wb_data_t rdat);
    wb_access(1'b0, adr, '0, rdat);
  endtask

  task automatic wait_cs(input logic level, input int max_cyc);
    int waited;
    waited = 0;
    while (cs_n !== level)
    begin
      if (waited == max_cyc)
        abort_run(level ? "chip select did not rise in time" : "chip select did not fall in time");
      @(posedge clk);
      #5;
      waited++;
    end
  endtask

  task automatic wait_sync_rises(input int n, input int max_cyc);
    logic prev;
    int   seen;
    int   waited;
    prev   = clk_sync;
    seen   = 0;
    waited = 0;
    while (seen < n)
    begin
      if (waited == max_cyc)
        abort_run("sync edges did not arrive in time");
      @(posedge clk);
      #5;
      waited++;
      if (clk_sync && !prev)
        seen++;
      prev = clk_sync;
    end
  endtask

  // fixed window, length set by the rate check
  task automatic count_sync_rises(input int cycles, output int n);
    logic prev;
    prev = clk_sync;
    n    = 0;
    repeat (cycles)
    begin
      @(posedge clk);
      #5;
      if (clk_sync && !prev)
        n++;
      prev = clk_sync;
    end
  endtask

  task automatic check_sync_count(input int n, input pa_t inc);
    real e;
    int  ei;
    e  = 4000.0 * real'(inc) / 4294967296.0;
    ei = int'(e);             // rounded
    assert (n >= ei - 1 && n <= ei + 1)
      else report_mismatch("sync edge count", n, ei);
  endtask

  task automatic wait_until_cycle(input int target);
    int waited;
    waited = 0;
    while (cyc_cnt < target)
    begin
      if (waited == 200000)
        abort_run("cycle target never reached");
      @(posedge clk);
      #5;
      waited++;
    end
  endtask

  // rising edge gap counted from the previous pulse, 10 cycles high
  task automatic pps_pulse_at(input int gap);
    wait_until_cycle(last_pps_cyc + gap);
    pps          = 1'b1;
    last_pps_cyc = cyc_cnt;
    wait_until_cycle(last_pps_cyc + 10);
    pps = 1'b0;
  endtask

  function automatic wb_data_t sext20(input logic [19:0] v);
    return {{12{v[19]}}, v};
  endfunction

  initial
  begin
    wb_data_t    rd;
    wb_data_t    c0;
    wb_data_t    c1;
    logic [71:0] data;
    logic [7:0]  cmd;
    int          n;
    int          r0;
    int          waited;
    wb_cyc      = 1'b0;
    wb_stb      = 1'b0;
    wb_we       = 1'b0;
    wb_adr      = '0;
    wb_dat_w    = '0;
    pps         = 1'b0;
    expect_idle = 1'b1;       // enable is 0 out of reset
    waited      = 0;
    while (!rst_n)
    begin
      if (waited == 20)
        abort_run("reset was never released");
      @(negedge clk);
      waited++;
    end
    @(posedge clk);
    #5;

    begin_test();
    assert (cs_n === 1'b1) else report_mismatch("o_spi_cs_n", cs_n, 1);
    assert (wb_ack === 1'b0) else report_mismatch("o_wb_ack", wb_ack, 0);
    assert (clk_sync === 1'b0) else report_mismatch("o_clk_sync", clk_sync, 0);
    wb_read(reg_pa_inc, rd);
    assert (rd === exp_inc) else report_mismatch("reg_pa_inc", rd, exp_inc);
    wb_read(reg_ctrl, rd);
    assert (rd === 32'd0) else report_mismatch("reg_ctrl", rd, 0);
    end_test("reset");

    begin_test();
    count_sync_rises(4000, n);
    check_sync_count(n, exp_inc);
    wb_write(reg_pa_inc, exp_inc * 2);
    count_sync_rises(4000, n);
    check_sync_count(n, exp_inc * 2);
    wb_write(reg_pa_inc, exp_inc); // back to the nominal rate
    end_test("sync rate");

    begin_test();
    expect_idle = 1'b0;
    wb_write(reg_ctrl, 32'd1);
    wait_cs(1'b0, 600);       // sync period about 200 cycles
    wait_cs(1'b1, 400);       // 80 sclk periods of 4 cycles
    data = served;            // copied before the next transfer starts
    cmd  = seen_cmd;
    assert (cmd === exp_cmd) else report_mismatch("command byte", cmd, exp_cmd);
    wb_read(reg_x, rd);
    assert (rd === sext20(data[71:52])) else report_mismatch("reg_x", rd, sext20(data[71:52]));
    wb_read(reg_y, rd);
    assert (rd === sext20(data[47:28])) else report_mismatch("reg_y", rd, sext20(data[47:28]));
    wb_read(reg_z, rd);
    assert (rd === sext20(data[23:4])) else report_mismatch("reg_z", rd, sext20(data[23:4]));
    end_test("sample read");

    begin_test();
    wb_write(reg_ctrl, 32'd0);
    wait_cs(1'b1, 400);       // let a running transfer finish
    wb_read(reg_count, c0);
    expect_idle = 1'b1;
    wait_sync_rises(3, 1000);
    wb_read(reg_count, c1);
    assert (c1 === c0) else report_mismatch("reg_count", c1, c0);
    expect_idle = 1'b0;
    r0 = cs_rise_cnt;
    wb_write(reg_ctrl, 32'd1);
    repeat (3)
    begin
      wait_cs(1'b0, 600);
      wait_cs(1'b1, 400);
    end
    wb_read(reg_count, rd);
    assert (rd === c1 + (cs_rise_cnt - r0))
      else report_mismatch("reg_count", rd, c1 + (cs_rise_cnt - r0));
    end_test("enable and count");

    begin_test();
    last_pps_cyc = cyc_cnt;
    pps_pulse_at(1);          // starts the first measured interval
    pps_pulse_at(100000);
    wb_read(reg_ctrl, rd);
    assert (rd[1] === 1'b1) else report_mismatch("pps_valid", rd[1], 1);
    pps_pulse_at(99800);      // below the 99950 lower bound
    wb_read(reg_ctrl, rd);
    assert (rd[1] === 1'b0) else report_mismatch("pps_valid", rd[1], 0);
    pps_pulse_at(100000);
    wb_read(reg_ctrl, rd);
    assert (rd[1] === 1'b1) else report_mismatch("pps_valid", rd[1], 1);
    wait_until_cycle(last_pps_cyc + 100200); // past the upper bound, no pulse
    wb_read(reg_ctrl, rd);
    assert (rd[1] === 1'b0) else report_mismatch("pps_valid", rd[1], 0);
    end_test("pps");

    $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/tb_clk_gen.sv
// testbench clock and power-on reset generator
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter real period_ns  = 40.0, // clock period
  parameter int  rst_cycles = 4     // rising edges with reset held low
)
(
  output logic o_clk,
  output logic o_rst_n
);

  initial
  begin
    o_clk = 1'b0;
    forever #(period_ns / 2.0) o_clk = ~o_clk;
  end

  initial
  begin
    o_rst_n = 1'b0;                     // asserted from time zero
    repeat (rst_cycles) @(posedge o_clk);
    #5;
    o_rst_n = 1'b1;                     // released off the edge
  end

endmodule

`default_nettype wire
